/* compile.f */
verilog/rv_dispatch_pkg.sv
verilog/rv_exec_pkg.sv
verilog/div_reservation_table.sv
verilog/phys_reg_file.sv
verilog/iter_divider.sv
verilog/cdb_arbiter.sv
verilog/div_cluster_top.sv
sim/tb_div_cluster.sv

/* sim/tb_div_cluster.sv */
`timescale 1ns/1ps

module tb_div_cluster;

    localparam int NUM_OPS        = 200;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 2000;
    // 0..2 hold fixed corner values, 3..7 belong to the outside producer
    localparam int FIRST_DEST     = 8;
    localparam int DEST_COUNT     = 64 - FIRST_DEST;

    logic                                  clk;
    logic                                  rst;
    rv_dispatch_pkg::dispatch_slot_t [1:0] dispatch;
    rv_exec_pkg::reg_write_t               ext_wr;
    logic                                  table_full;
    rv_exec_pkg::cdb_t                     cdb;

    integer seed;
    int     cycle_cnt;
    int     n_built;
    int     n_done;

    // register model, value and written flag per physical register
    logic [31:0] model_val [64];
    logic        model_rdy [64];
    logic        mapped [64];
    logic        in_flight [64];
    // outstanding readers, a register is not reused while nonzero
    int          uses [64];

    // scoreboard keyed by rob_id
    rv_dispatch_pkg::dispatch_slot_t rob_info [64];
    logic                            outstanding [64];
    rv_dispatch_pkg::rob_id_t        next_rob;

    // group waiting to be taken by the table
    rv_dispatch_pkg::dispatch_slot_t [1:0] grp;
    int                                    grp_n;
    logic                                  last_full;
    logic                                  saw_full;
    logic                                  started;

    // one late outside write at a time
    logic                   pend_active;
    rv_dispatch_pkg::preg_t pend_reg;
    int                     pend_delay;
    rv_dispatch_pkg::preg_t last_rd;
    logic                   have_last;

    div_cluster_top #(
        .DISPATCH_WIDTH(2),
        .TABLE_DEPTH   (8),
        .PREG_COUNT    (64)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (dispatch),
        .ext_wr    (ext_wr),
        .table_full(table_full),
        .cdb       (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    // RISC-V M extension results
    function automatic logic [31:0] ref_div(input rv_dispatch_pkg::div_op_t op,
                                            input logic [31:0] a, input logic [31:0] b);
        logic        is_rem;
        logic        is_uns;
        logic [31:0] q;
        logic [31:0] r;
        is_rem = (op == rv_dispatch_pkg::REM) || (op == rv_dispatch_pkg::REMU);
        is_uns = (op == rv_dispatch_pkg::DIVU) || (op == rv_dispatch_pkg::REMU);
        if (b == 32'd0) begin
            q = '1;
            r = a;
        end else if (is_uns) begin
            q = a / b;
            r = a % b;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            // signed overflow
            q = a;
            r = '0;
        end else begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
        return is_rem ? r : q;
    endfunction

    // outside reg, any mapped divide result, or often the newest destination
    function automatic rv_dispatch_pkg::preg_t pick_src();
        int r;
        r = 3 + $unsigned($random(seed)) % 61;
        if (have_last && ($unsigned($random(seed)) % 4 == 0)) begin
            r = last_rd;
        end else if (r >= FIRST_DEST && !mapped[r]) begin
            r = 3 + $unsigned($random(seed)) % 5;
        end
        return rv_dispatch_pkg::preg_t'(r);
    endfunction

    // fresh destination, not in flight and with no pending reader
    task automatic alloc_dest(output rv_dispatch_pkg::preg_t rd);
        int   start;
        int   r;
        logic found;
        found = 1'b0;
        rd    = '0;
        start = $unsigned($random(seed)) % DEST_COUNT;
        for (int k = 0; k < DEST_COUNT; k++) begin
            r = FIRST_DEST + (start + k) % DEST_COUNT;
            if (!found && !in_flight[r] && uses[r] == 0) begin
                rd    = rv_dispatch_pkg::preg_t'(r);
                found = 1'b1;
            end
        end
        assert (found) else stop_on_error("no free destination register left");
    endtask

    task automatic build_op(output rv_dispatch_pkg::dispatch_slot_t s);
        int         kind;
        int         r;
        logic [1:0] op_bits;
        s       = '0;
        s.valid = 1'b1;
        op_bits = $random(seed);
        s.op    = rv_dispatch_pkg::div_op_t'(op_bits);
        kind    = $unsigned($random(seed)) % 8;
        if (kind == 0) begin
            // divide by zero, or most negative by minus one
            if ($random(seed) & 1) begin
                s.rs1 = pick_src();
                s.rs2 = 6'd0;
            end else begin
                s.rs1 = 6'd1;
                s.rs2 = 6'd2;
            end
        end else begin
            s.rs1 = pick_src();
            s.rs2 = pick_src();
            r     = 3 + $unsigned($random(seed)) % 5;
            if (kind == 1 && !pend_active && uses[r] == 0) begin
                // outside producer writes this one later
                pend_active  = 1'b1;
                pend_reg     = rv_dispatch_pkg::preg_t'(r);
                pend_delay   = 10 + $unsigned($random(seed)) % 40;
                model_rdy[r] = 1'b0;
                s.rs2        = rv_dispatch_pkg::preg_t'(r);
            end
        end
        // count readers first so rd never equals a source
        uses[s.rs1]++;
        uses[s.rs2]++;
        alloc_dest(s.rd);
        assert (!outstanding[next_rob]) else stop_on_error("rob_id reused while outstanding");
        s.rob_id              = next_rob;
        next_rob              = next_rob + 1'b1;
        in_flight[s.rd]       = 1'b1;
        mapped[s.rd]          = 1'b1;
        model_rdy[s.rd]       = 1'b0;
        outstanding[s.rob_id] = 1'b1;
        rob_info[s.rob_id]    = s;
        last_rd               = s.rd;
        have_last             = 1'b1;
    endtask

    // scoreboard, called once per cycle at the falling edge
    task automatic check_cdb();
        rv_dispatch_pkg::dispatch_slot_t s;
        logic [31:0]                     exp;
        if (cdb.valid) begin
            assert (started) else stop_on_error("cdb packet appeared before the first dispatch");
            assert (outstanding[cdb.rob_id]) else
                stop_on_error($sformatf("cdb packet for rob_id %0d which is not outstanding",
                                        cdb.rob_id));
            s = rob_info[cdb.rob_id];
            assert (cdb.rd == s.rd) else
                stop_on_error($sformatf("FAILED cdb.rd exp %h got %h", s.rd, cdb.rd));
            assert (model_rdy[s.rs1] && model_rdy[s.rs2]) else
                stop_on_error("result appeared before its source registers were written");
            exp = ref_div(s.op, model_val[s.rs1], model_val[s.rs2]);
            assert (cdb.value == exp) else
                stop_on_error($sformatf("FAILED cdb.value exp %h got %h", exp, cdb.value));
            // model keeps its own result for later readers
            model_val[s.rd]        = exp;
            model_rdy[s.rd]        = 1'b1;
            in_flight[s.rd]        = 1'b0;
            uses[s.rs1]--;
            uses[s.rs2]--;
            outstanding[s.rob_id] = 1'b0;
            n_done++;
        end
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d of %0d divides done",
                 cycle_cnt, n_done, NUM_OPS);
        $display("sim failed");
        $fatal(1, "run did not finish in time");
    end

    initial begin : stimulus
        rv_exec_pkg::reg_write_t               w;
        rv_dispatch_pkg::dispatch_slot_t       s;
        rv_dispatch_pkg::dispatch_slot_t [1:0] slots;
        seed        = 8;
        rst         = 1'b1;
        dispatch    = '0;
        ext_wr      = '0;
        n_built     = 0;
        n_done      = 0;
        grp         = '0;
        grp_n       = 0;
        last_full   = 1'b0;
        saw_full    = 1'b0;
        started     = 1'b0;
        pend_active = 1'b0;
        pend_reg    = '0;
        pend_delay  = 0;
        last_rd     = '0;
        have_last   = 1'b0;
        next_rob    = '0;
        for (int r = 0; r < 64; r++) begin
            model_val[r]   = '0;
            model_rdy[r]   = 1'b0;
            mapped[r]      = 1'b0;
            in_flight[r]   = 1'b0;
            uses[r]        = 0;
            outstanding[r] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!table_full && !cdb.valid) else
            stop_on_error("table_full or cdb.valid high after reset");

        // preload every register through the outside port
        for (int r = 0; r < 64; r++) begin
            @(posedge clk);
            w.valid = 1'b1;
            w.preg  = rv_dispatch_pkg::preg_t'(r);
            if (r == 0) begin
                w.data = 32'h0000_0000;
            end else if (r == 1) begin
                w.data = 32'h8000_0000;
            end else if (r == 2) begin
                w.data = 32'hffff_ffff;
            end else begin
                w.data = $random(seed);
            end
            ext_wr <= w;
            model_val[r] = w.data;
            model_rdy[r] = 1'b1;
            @(negedge clk);
            check_cdb();
        end

        while (n_done < NUM_OPS) begin
            @(posedge clk);
            w = '0;
            if (pend_active) begin
                if (pend_delay == 0) begin
                    w.valid               = 1'b1;
                    w.preg                = pend_reg;
                    w.data                = $random(seed);
                    model_val[pend_reg]   = w.data;
                    model_rdy[pend_reg]   = 1'b1;
                    pend_active           = 1'b0;
                end else begin
                    pend_delay--;
                end
            end
            ext_wr <= w;

            // mostly two per cycle, an idle gap now and then
            if (grp_n == 0 && !last_full && n_built < NUM_OPS &&
                ($unsigned($random(seed)) % 8 != 0)) begin
                grp   = '0;
                grp_n = ($unsigned($random(seed)) % 4 == 0) ? 1 : 2;
                if (grp_n > NUM_OPS - n_built) begin
                    grp_n = NUM_OPS - n_built;
                end
                for (int i = 0; i < grp_n; i++) begin
                    build_op(s);
                    grp[i] = s;
                end
                n_built += grp_n;
                started = 1'b1;
            end

            // ready bits from the current model, also on a retry
            slots = '0;
            if (grp_n != 0 && !last_full) begin
                slots = grp;
                for (int i = 0; i < 2; i++) begin
                    if (grp[i].valid) begin
                        slots[i].rs1_ready = model_rdy[grp[i].rs1];
                        slots[i].rs2_ready = model_rdy[grp[i].rs2];
                    end
                end
            end
            dispatch <= slots;

            @(negedge clk);
            // table_full here is what the table sees at the next edge
            last_full = table_full;
            if (table_full) begin
                saw_full = 1'b1;
            end
            if (slots[0].valid && !table_full) begin
                grp_n = 0;
            end
            check_cdb();
        end

        // drain, any further packet is a duplicate
        repeat (50) begin
            @(posedge clk);
            ext_wr   <= '0;
            dispatch <= '0;
            @(negedge clk);
            check_cdb();
        end

        if (saw_full && n_done == NUM_OPS) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("table_full never went high during the dispatch bursts");
            $display("sim failed");
            $fatal(1, "back-pressure was not exercised");
        end
    end

endmodule

/* verilog/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                           clk,
    input  logic                           rst,
    input  rv_exec_pkg::div_result_t [1:0] results,
    output logic [1:0]                     grant,
    output logic [1:0]                     unit_release,
    output rv_exec_pkg::cdb_t              cdb
);

    // unit that won the last contested or uncontested grant
    logic last_win;

    always_comb begin
        grant = 2'b00;
        if (results[0].valid && results[1].valid) begin
            // loser of last time goes first
            grant = last_win ? 2'b01 : 2'b10;
        end else if (results[0].valid) begin
            grant = 2'b01;
        end else if (results[1].valid) begin
            grant = 2'b10;
        end
    end

    // table busy flag drops on the same edge the divider lets go
    assign unit_release = grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
            last_win  <= 1'b1;
        end else begin
            cdb.valid  <= |grant;
            cdb.rd     <= grant[1] ? results[1].rd : results[0].rd;
            cdb.rob_id <= grant[1] ? results[1].rob_id : results[0].rob_id;
            cdb.value  <= grant[1] ? results[1].value : results[0].value;
            if (|grant) begin
                last_win <= grant[1];
            end
        end
    end

endmodule

/* verilog/div_cluster_top.sv */
`timescale 1ns/1ps

module div_cluster_top #(
    parameter int DISPATCH_WIDTH = 2,
    parameter int TABLE_DEPTH    = 8,
    parameter int PREG_COUNT     = 64
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  rv_dispatch_pkg::dispatch_slot_t [DISPATCH_WIDTH-1:0] dispatch,
    input  rv_exec_pkg::reg_write_t                              ext_wr,
    output logic                                                 table_full,
    output rv_exec_pkg::cdb_t                                    cdb
);

    rv_dispatch_pkg::issue_t [1:0]      issue;
    rv_exec_pkg::operand_t [1:0]        operands;
    rv_exec_pkg::div_result_t [1:0]     results;
    logic [1:0]                         grant;
    logic [1:0]                         unit_release;

    div_reservation_table #(
        .DISPATCH_WIDTH(DISPATCH_WIDTH),
        .TABLE_DEPTH   (TABLE_DEPTH)
    ) i_table (
        .clk         (clk),
        .rst         (rst),
        .dispatch    (dispatch),
        .ext_wr      (ext_wr),
        .cdb         (cdb),
        .unit_release(unit_release),
        .table_full  (table_full),
        .issue       (issue)
    );

    phys_reg_file #(
        .PREG_COUNT(PREG_COUNT)
    ) i_prf (
        .clk     (clk),
        .rst     (rst),
        .ext_wr  (ext_wr),
        .cdb     (cdb),
        .issue   (issue),
        .operands(operands)
    );

    // unit 0, DIV and REM
    iter_divider #(
        .DIV_SIGNED(1'b1)
    ) i_div_signed (
        .clk    (clk),
        .rst    (rst),
        .operand(operands[0]),
        .grant  (grant[0]),
        .result (results[0])
    );

    // unit 1, DIVU and REMU
    iter_divider #(
        .DIV_SIGNED(1'b0)
    ) i_div_unsigned (
        .clk    (clk),
        .rst    (rst),
        .operand(operands[1]),
        .grant  (grant[1]),
        .result (results[1])
    );

    cdb_arbiter i_arbiter (
        .clk         (clk),
        .rst         (rst),
        .results     (results),
        .grant       (grant),
        .unit_release(unit_release),
        .cdb         (cdb)
    );

endmodule

/* verilog/div_reservation_table.sv */
`timescale 1ns/1ps

module div_reservation_table #(
    parameter int DISPATCH_WIDTH = 2,
    parameter int TABLE_DEPTH    = 8
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  rv_dispatch_pkg::dispatch_slot_t [DISPATCH_WIDTH-1:0] dispatch,
    input  rv_exec_pkg::reg_write_t                              ext_wr,
    input  rv_exec_pkg::cdb_t                                    cdb,
    input  logic [1:0]                                           unit_release,
    output logic                                                 table_full,
    output rv_dispatch_pkg::issue_t [1:0]                        issue
);

    localparam int IDX_W = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;
    localparam int CNT_W = $clog2(TABLE_DEPTH + 1);

    rv_dispatch_pkg::rs_entry_t [TABLE_DEPTH-1:0] entries;

    // one flag per unit, set at issue, cleared by the arbiter
    logic [1:0] busy;

    logic [CNT_W-1:0]                     free_count;
    logic [TABLE_DEPTH-1:0]               claimed;
    logic [DISPATCH_WIDTH-1:0]            slot_found;
    logic [DISPATCH_WIDTH-1:0][IDX_W-1:0] slot_idx;
    logic [1:0]                           sel_found;
    logic [1:0][IDX_W-1:0]                sel_idx;

    // a register is written this cycle by the outside port or the cdb
    function automatic logic woken(input rv_dispatch_pkg::preg_t r);
        return (ext_wr.valid && (ext_wr.preg == r)) || (cdb.valid && (cdb.rd == r));
    endfunction

    // occupancy
    always_comb begin
        free_count = '0;
        for (int j = 0; j < TABLE_DEPTH; j++) begin
            if (!entries[j].valid) begin
                free_count = free_count + 1'b1;
            end
        end
    end

    // not enough room for a full dispatch group
    assign table_full = (int'(free_count) < DISPATCH_WIDTH);

    // lowest free entry for each valid slot, in slot order
    always_comb begin
        claimed    = '0;
        slot_found = '0;
        slot_idx   = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < TABLE_DEPTH; j++) begin
                if (dispatch[i].valid && !slot_found[i] && !entries[j].valid && !claimed[j]) begin
                    slot_found[i] = 1'b1;
                    slot_idx[i]   = IDX_W'(j);
                    claimed[j]    = 1'b1;
                end
            end
        end
    end

    // per unit pick, unit 0 takes signed ops, unit 1 unsigned
    // walk downwards so the lowest ready index wins
    always_comb begin
        sel_found = '0;
        sel_idx   = '0;
        for (int u = 0; u < 2; u++) begin
            for (int j = TABLE_DEPTH - 1; j >= 0; j--) begin
                if (!busy[u] && entries[j].valid && entries[j].rs1_ready &&
                    entries[j].rs2_ready && (entries[j].op[0] == u[0])) begin
                    sel_found[u] = 1'b1;
                    sel_idx[u]   = IDX_W'(j);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < TABLE_DEPTH; j++) begin
                entries[j].valid <= 1'b0;
            end
            busy           <= '0;
            issue[0].valid <= 1'b0;
            issue[1].valid <= 1'b0;
        end else begin
            // wakeup of stored entries
            for (int j = 0; j < TABLE_DEPTH; j++) begin
                if (woken(entries[j].rs1)) begin
                    entries[j].rs1_ready <= 1'b1;
                end
                if (woken(entries[j].rs2)) begin
                    entries[j].rs2_ready <= 1'b1;
                end
            end

            // issue, frees the entry and marks the unit busy
            for (int u = 0; u < 2; u++) begin
                issue[u].valid <= sel_found[u];
                issue[u].op    <= entries[sel_idx[u]].op;
                issue[u].rs1   <= entries[sel_idx[u]].rs1;
                issue[u].rs2   <= entries[sel_idx[u]].rs2;
                issue[u].rd    <= entries[sel_idx[u]].rd;
                issue[u].rob_id <= entries[sel_idx[u]].rob_id;
                if (sel_found[u]) begin
                    entries[sel_idx[u]].valid <= 1'b0;
                    busy[u]                   <= 1'b1;
                end else if (unit_release[u]) begin
                    busy[u] <= 1'b0;
                end
            end

            // accept the group only when there is room for all of it
            // incoming slots only land in free entries, never in one being issued
            if (!table_full) begin
                for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                    if (slot_found[i]) begin
                        entries[slot_idx[i]] <= rv_dispatch_pkg::rs_entry_t'(dispatch[i]);
                        entries[slot_idx[i]].rs1_ready <=
                            dispatch[i].rs1_ready | woken(dispatch[i].rs1);
                        entries[slot_idx[i]].rs2_ready <=
                            dispatch[i].rs2_ready | woken(dispatch[i].rs2);
                    end
                end
            end
        end
    end

endmodule

/* verilog/iter_divider.sv */
`timescale 1ns/1ps

module iter_divider #(
    parameter bit DIV_SIGNED = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst,
    input  rv_exec_pkg::operand_t    operand,
    input  logic                     grant,
    output rv_exec_pkg::div_result_t result
);

    localparam int XLEN = rv_exec_pkg::XLEN;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FIX,
        ST_DONE
    } div_state_t;

    div_state_t state;
    logic [4:0] step_cnt;

    // partial remainder and quotient shift pair
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] div_mag;
    // original dividend, needed for divide by zero
    logic [XLEN-1:0] dividend_q;
    logic            neg_quo;
    logic            neg_rem;
    logic            div_zero;
    logic            want_rem;

    logic            src1_neg;
    logic            src2_neg;
    logic [XLEN-1:0] mag1;
    logic [XLEN-1:0] mag2;
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   trial;
    logic [XLEN-1:0] quo_final;
    logic [XLEN-1:0] rem_final;

    // magnitudes, unsigned unit never sees a sign
    assign src1_neg = DIV_SIGNED && operand.src1[XLEN-1];
    assign src2_neg = DIV_SIGNED && operand.src2[XLEN-1];
    assign mag1     = src1_neg ? -operand.src1 : operand.src1;
    assign mag2     = src2_neg ? -operand.src2 : operand.src2;

    // one restoring step, borrow out means restore
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign trial   = shifted - {1'b0, div_mag};

    // sign fix
    // most negative / -1 falls out naturally as 0x80000000 rem 0
    // divide by zero skips the fix entirely
    assign quo_final = div_zero ? '1 : (neg_quo ? -quo_q : quo_q);
    assign rem_final = div_zero ? dividend_q : (neg_rem ? -rem_q : rem_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            step_cnt     <= '0;
            result.valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (operand.valid) begin
                        rem_q         <= '0;
                        quo_q         <= mag1;
                        div_mag       <= mag2;
                        dividend_q    <= operand.src1;
                        neg_quo       <= src1_neg ^ src2_neg;
                        neg_rem       <= src1_neg;
                        div_zero      <= (operand.src2 == '0);
                        want_rem      <= operand.op[1];
                        result.rd     <= operand.rd;
                        result.rob_id <= operand.rob_id;
                        step_cnt      <= '0;
                        state         <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    quo_q    <= {quo_q[XLEN-2:0], ~trial[XLEN]};
                    rem_q    <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
                    step_cnt <= step_cnt + 5'd1;
                    // 32nd step
                    if (step_cnt == 5'd31) begin
                        state <= ST_FIX;
                    end
                end
                ST_FIX: begin
                    result.valid <= 1'b1;
                    result.value <= want_rem ? rem_final : quo_final;
                    state        <= ST_DONE;
                end
                ST_DONE: begin
                    // hold until the bus takes it
                    if (grant) begin
                        result.valid <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/phys_reg_file.sv */
`timescale 1ns/1ps

module phys_reg_file #(
    parameter int PREG_COUNT = 64
) (
    input  logic                            clk,
    input  logic                            rst,
    input  rv_exec_pkg::reg_write_t         ext_wr,
    input  rv_exec_pkg::cdb_t               cdb,
    input  rv_dispatch_pkg::issue_t [1:0]   issue,
    output rv_exec_pkg::operand_t [1:0]     operands
);

    logic [rv_exec_pkg::XLEN-1:0] regs [PREG_COUNT];

    // two write ports
    // never the same register in one cycle, outside port only hits non-divide producers
    always_ff @(posedge clk) begin
        if (ext_wr.valid) begin
            regs[ext_wr.preg] <= ext_wr.data;
        end
        if (cdb.valid) begin
            regs[cdb.rd] <= cdb.value;
        end
    end

    // registered operand read, one packet per unit
    // ready bits lead the read by two edges so no bypass is needed
    always_ff @(posedge clk) begin
        if (rst) begin
            operands[0].valid <= 1'b0;
            operands[1].valid <= 1'b0;
        end else begin
            for (int u = 0; u < 2; u++) begin
                operands[u].valid  <= issue[u].valid;
                operands[u].op     <= issue[u].op;
                operands[u].rd     <= issue[u].rd;
                operands[u].rob_id <= issue[u].rob_id;
                operands[u].src1   <= regs[issue[u].rs1];
                operands[u].src2   <= regs[issue[u].rs2];
            end
        end
    end

endmodule

/* verilog/rv_dispatch_pkg.sv */
package rv_dispatch_pkg;

    // physical register number, 64 registers
    typedef logic [5:0] preg_t;

    // reorder buffer tag, carried through to the cdb
    typedef logic [5:0] rob_id_t;

    // bit 0 set -> unsigned, bit 1 set -> remainder
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    // one slot of a dispatch group
    typedef struct packed {
        logic    valid;
        div_op_t op;
        preg_t   rs1;
        logic    rs1_ready;
        preg_t   rs2;
        logic    rs2_ready;
        preg_t   rd;
        rob_id_t rob_id;
    } dispatch_slot_t;

    // table entry, valid means occupied
    typedef struct packed {
        logic    valid;
        div_op_t op;
        preg_t   rs1;
        logic    rs1_ready;
        preg_t   rs2;
        logic    rs2_ready;
        preg_t   rd;
        rob_id_t rob_id;
    } rs_entry_t;

    // instruction leaving the table towards the register file
    typedef struct packed {
        logic    valid;
        div_op_t op;
        preg_t   rs1;
        preg_t   rs2;
        preg_t   rd;
        rob_id_t rob_id;
    } issue_t;

endpackage

/* verilog/rv_exec_pkg.sv */
package rv_exec_pkg;

    localparam int XLEN = 32;

    // register file write, used by the outside producer port
    typedef struct packed {
        logic                  valid;
        rv_dispatch_pkg::preg_t preg;
        logic [XLEN-1:0]       data;
    } reg_write_t;

    // issued instruction with its source values
    typedef struct packed {
        logic                     valid;
        rv_dispatch_pkg::div_op_t op;
        rv_dispatch_pkg::preg_t   rd;
        rv_dispatch_pkg::rob_id_t rob_id;
        logic [XLEN-1:0]          src1;
        logic [XLEN-1:0]          src2;
    } operand_t;

    // finished divide, held until the arbiter takes it
    typedef struct packed {
        logic                     valid;
        rv_dispatch_pkg::preg_t   rd;
        rv_dispatch_pkg::rob_id_t rob_id;
        logic [XLEN-1:0]          value;
    } div_result_t;

    // common data bus packet
    typedef struct packed {
        logic                     valid;
        rv_dispatch_pkg::preg_t   rd;
        rv_dispatch_pkg::rob_id_t rob_id;
        logic [XLEN-1:0]          value;
    } cdb_t;

endpackage
